// File: Bender.yml
package:
  name: xbar

sources:
  - design/xbar_pkg.sv
  - design/xbar_rr_arbiter.sv
  - design/xbar_slave_port.sv
  - design/xbar_return_router.sv
  - design/xbar_top.sv
  - target: test
    files:
      - test/xbar_slave_model.sv
      - test/xbar_tb.sv

// File: design/xbar_pkg.sv
// Shared widths and types for the crossbar.
// The slave-select field starts at SEL_LSB and is log2(NUM_SLAVES) bits wide,
// so NUM_SLAVES must be a power of two no larger than 4 with these widths.
// Commands are a single bit, and only reads produce a response.

package xbar_pkg;

	// ----------------------------------------------------------------------
	// widths
	// ----------------------------------------------------------------------
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;

	// lowest bit of the slave-select field in the address
	localparam int SEL_LSB = 30;

	// ----------------------------------------------------------------------
	// payload types
	// ----------------------------------------------------------------------
	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [DATA_WIDTH-1:0] data_t;

	// read returns rdata with resp one cycle after ack, write has no resp
	typedef enum logic
	{
		CMD_READ  = 1'b0,
		CMD_WRITE = 1'b1
	} cmd_e;

endpackage

// File: design/xbar_return_router.sv
// Routes each slave's ack, resp and rdata back to the master it serves.
// Purely combinational. ack follows the live grant, while resp and rdata
// follow the registered response grant of the same slave.
// A master's rdata is zero outside its resp cycle.

`timescale 1ns/100ps

module xbar_return_router
#(
	parameter int NUM_MASTERS = 4,
	parameter int NUM_SLAVES  = 4
)
(
	// per-slave grants from the slave ports
	input  logic [NUM_SLAVES-1:0][NUM_MASTERS-1:0] grant,
	input  logic [NUM_SLAVES-1:0][NUM_MASTERS-1:0] resp_grant,

	// slave returns
	input  logic [NUM_SLAVES-1:0]                  s_ack,
	input  logic [NUM_SLAVES-1:0]                  s_resp,
	input  xbar_pkg::data_t [NUM_SLAVES-1:0]       s_rdata,

	// master returns
	output logic [NUM_MASTERS-1:0]                 m_ack,
	output logic [NUM_MASTERS-1:0]                 m_resp,
	output xbar_pkg::data_t [NUM_MASTERS-1:0]      m_rdata
);

	// ----------------------------------------------------------------------
	// ack, same cycle as the slave's
	// ----------------------------------------------------------------------
	always_comb
	begin
		m_ack = '0;
		for (int m = 0; m < NUM_MASTERS; m++)
			for (int s = 0; s < NUM_SLAVES; s++)
				if (s_ack[s] && grant[s][m])
					m_ack[m] = 1'b1;
	end

	// ----------------------------------------------------------------------
	// read return, one cycle after ack
	// ----------------------------------------------------------------------
	always_comb
	begin
		m_resp  = '0;
		m_rdata = '0;
		for (int m = 0; m < NUM_MASTERS; m++)
		begin
			for (int s = 0; s < NUM_SLAVES; s++)
			begin
				// at most one slave names a given master here
				if (s_resp[s] && resp_grant[s][m])
				begin
					m_resp[m]  = 1'b1;
					m_rdata[m] = s_rdata[s];
				end
			end
		end
	end

endmodule

// File: design/xbar_rr_arbiter.sv
// Round-robin arbiter for one slave.
// req must already be filtered to masters that address this slave.
// A grant is combinational while free, then held until ack, so a master
// must keep its request up until it is acked.

`timescale 1ns/100ps

module xbar_rr_arbiter
#(
	parameter int NUM_MASTERS = 4
)
(
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic [NUM_MASTERS-1:0] req,
	input  logic                   ack,
	output logic [NUM_MASTERS-1:0] grant
);

	localparam int PTR_W = $clog2(NUM_MASTERS);

	logic [PTR_W-1:0]       ptr;
	logic                   locked;
	logic [NUM_MASTERS-1:0] lock_grant;
	logic [NUM_MASTERS-1:0] pick;
	logic [PTR_W-1:0]       served;
	int                     idx;

	// first requester at or after ptr, scanned backwards so the nearest wins
	always_comb
	begin
		pick = '0;
		idx  = 0;
		for (int k = NUM_MASTERS - 1; k >= 0; k--)
		begin
			idx = int'(ptr) + k;
			if (idx >= NUM_MASTERS)
				idx = idx - NUM_MASTERS;
			if (req[idx])
			begin
				pick      = '0;
				pick[idx] = 1'b1;
			end
		end
	end

	assign grant = locked ? lock_grant : pick;

	// index of the master being served
	always_comb
	begin
		served = '0;
		for (int i = 0; i < NUM_MASTERS; i++)
			if (grant[i])
				served = PTR_W'(i);
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			ptr        <= '0;
			locked     <= 1'b0;
			lock_grant <= '0;
		end
		else if (ack && |grant)
		begin
			locked     <= 1'b0;
			lock_grant <= '0;
			ptr        <= (served == PTR_W'(NUM_MASTERS - 1)) ? '0 : served + 1'b1;
		end
		else if (!locked && |pick)
		begin
			// hold the choice so the slave sees stable fields
			locked     <= 1'b1;
			lock_grant <= pick;
		end
	end

endmodule

// File: design/xbar_slave_port.sv
// Request side of one slave: address filter, arbiter and request mux.
// Slave outputs are all zero while no master is granted.
// resp_grant holds the granted master for one cycle after an acked read,
// which is the cycle the slave is expected to return resp and rdata.

`timescale 1ns/100ps

module xbar_slave_port
#(
	parameter int NUM_MASTERS = 4,
	parameter int NUM_SLAVES  = 4,
	parameter int SLAVE_ID    = 0
)
(
	input  logic                                   clk,
	input  logic                                   reset_n,

	// master side, one entry per master
	input  logic [NUM_MASTERS-1:0]                 m_req,
	input  xbar_pkg::addr_t [NUM_MASTERS-1:0]      m_addr,
	input  xbar_pkg::cmd_e [NUM_MASTERS-1:0]       m_cmd,
	input  xbar_pkg::data_t [NUM_MASTERS-1:0]      m_wdata,

	// this slave
	output logic                                   s_req,
	output xbar_pkg::addr_t                        s_addr,
	output xbar_pkg::cmd_e                         s_cmd,
	output xbar_pkg::data_t                        s_wdata,
	input  logic                                   s_ack,

	// to the return router
	output logic [NUM_MASTERS-1:0]                 grant,
	output logic [NUM_MASTERS-1:0]                 resp_grant
);

	localparam int SEL_W = $clog2(NUM_SLAVES);

	logic [NUM_MASTERS-1:0] hit_req;

	// ----------------------------------------------------------------------
	// address decode
	// ----------------------------------------------------------------------
	always_comb
	begin
		for (int i = 0; i < NUM_MASTERS; i++)
			hit_req[i] = m_req[i] &&
				(m_addr[i][xbar_pkg::SEL_LSB +: SEL_W] == SEL_W'(SLAVE_ID));
	end

	xbar_rr_arbiter
	#(
		.NUM_MASTERS (NUM_MASTERS)
	)
	u_arbiter
	(
		.clk     (clk),
		.reset_n (reset_n),
		.req     (hit_req),
		.ack     (s_ack),
		.grant   (grant)
	);

	// ----------------------------------------------------------------------
	// request mux, grant is one-hot or empty
	// ----------------------------------------------------------------------
	always_comb
	begin
		s_req   = 1'b0;
		s_addr  = '0;
		s_cmd   = xbar_pkg::CMD_READ;
		s_wdata = '0;
		for (int i = 0; i < NUM_MASTERS; i++)
		begin
			if (grant[i])
			begin
				s_req   = m_req[i];
				s_addr  = m_addr[i];
				s_cmd   = m_cmd[i];
				s_wdata = m_wdata[i];
			end
		end
	end

	// remember who gets the read data next cycle
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			resp_grant <= '0;
		else if (s_ack && s_cmd == xbar_pkg::CMD_READ)
			resp_grant <= grant;
		else
			resp_grant <= '0;
	end

endmodule

// File: design/xbar_top.sv
// Crossbar of NUM_MASTERS masters onto NUM_SLAVES slaves.
// The slave is chosen by the top address bits; each slave has its own
// round-robin arbiter. Masters hold req and fields until m_ack.
// A read returns m_resp with m_rdata one cycle after m_ack.
// NUM_MASTERS >= 2; NUM_SLAVES a power of two from 2 to 4.

`timescale 1ns/100ps

module xbar_top
#(
	parameter int NUM_MASTERS = 4,
	parameter int NUM_SLAVES  = 4
)
(
	input  logic                                clk,
	input  logic                                reset_n,

	// master side
	input  logic [NUM_MASTERS-1:0]              m_req,
	input  xbar_pkg::addr_t [NUM_MASTERS-1:0]   m_addr,
	input  xbar_pkg::cmd_e [NUM_MASTERS-1:0]    m_cmd,
	input  xbar_pkg::data_t [NUM_MASTERS-1:0]   m_wdata,
	output logic [NUM_MASTERS-1:0]              m_ack,
	output logic [NUM_MASTERS-1:0]              m_resp,
	output xbar_pkg::data_t [NUM_MASTERS-1:0]   m_rdata,

	// slave side
	output logic [NUM_SLAVES-1:0]               s_req,
	output xbar_pkg::addr_t [NUM_SLAVES-1:0]    s_addr,
	output xbar_pkg::cmd_e [NUM_SLAVES-1:0]     s_cmd,
	output xbar_pkg::data_t [NUM_SLAVES-1:0]    s_wdata,
	input  logic [NUM_SLAVES-1:0]               s_ack,
	input  logic [NUM_SLAVES-1:0]               s_resp,
	input  xbar_pkg::data_t [NUM_SLAVES-1:0]    s_rdata
);

	logic [NUM_SLAVES-1:0][NUM_MASTERS-1:0] grant;
	logic [NUM_SLAVES-1:0][NUM_MASTERS-1:0] resp_grant;

	// ----------------------------------------------------------------------
	// one request path per slave
	// ----------------------------------------------------------------------
	for (genvar g = 0; g < NUM_SLAVES; g++)
	begin : g_slave
		xbar_slave_port
		#(
			.NUM_MASTERS (NUM_MASTERS),
			.NUM_SLAVES  (NUM_SLAVES),
			.SLAVE_ID    (g)
		)
		u_slave_port
		(
			.clk        (clk),
			.reset_n    (reset_n),
			.m_req      (m_req),
			.m_addr     (m_addr),
			.m_cmd      (m_cmd),
			.m_wdata    (m_wdata),
			.s_req      (s_req[g]),
			.s_addr     (s_addr[g]),
			.s_cmd      (s_cmd[g]),
			.s_wdata    (s_wdata[g]),
			.s_ack      (s_ack[g]),
			.grant      (grant[g]),
			.resp_grant (resp_grant[g])
		);
	end

	// returns back to the masters
	xbar_return_router
	#(
		.NUM_MASTERS (NUM_MASTERS),
		.NUM_SLAVES  (NUM_SLAVES)
	)
	u_return_router
	(
		.grant      (grant),
		.resp_grant (resp_grant),
		.s_ack      (s_ack),
		.s_resp     (s_resp),
		.s_rdata    (s_rdata),
		.m_ack      (m_ack),
		.m_resp     (m_resp),
		.m_rdata    (m_rdata)
	);

endmodule

// File: test/xbar_slave_model.sv
// Behavioral memory slave for the crossbar testbench, not for synthesis.
// 16 words indexed by address bits 5:2, preloaded from SLAVE_ID and the word index.
// ack comes after 'delay' extra cycles of a held request.
// A read returns rdata with resp in the cycle after ack.

`timescale 1ns/100ps

module xbar_slave_model
#(
	parameter int SLAVE_ID = 0
)
(
	input  logic            clk,
	input  logic            reset_n,
	input  logic [1:0]      delay,
	input  logic            req,
	input  xbar_pkg::addr_t addr,
	input  xbar_pkg::cmd_e  cmd,
	input  xbar_pkg::data_t wdata,
	output logic            ack,
	output logic            resp,
	output xbar_pkg::data_t rdata
);

	xbar_pkg::data_t mem [16];
	logic [1:0]      waited;

	// preload pattern, unique per slave and per word
	function automatic xbar_pkg::data_t fill_word(input int word);
		return 32'hA000_0000 | (32'(SLAVE_ID) << 24) | (32'(word) << 8) | 32'(word ^ 15);
	endfunction

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			ack    <= 1'b0;
			resp   <= 1'b0;
			rdata  <= '0;
			waited <= '0;
			for (int i = 0; i < 16; i++)
				mem[i] <= fill_word(i);
		end
		else
		begin
			ack  <= 1'b0;
			resp <= 1'b0;
			if (ack && req)
			begin
				// fields are still held in the ack cycle
				if (cmd == xbar_pkg::CMD_WRITE)
					mem[addr[5:2]] <= wdata;
				else
				begin
					resp  <= 1'b1;
					rdata <= mem[addr[5:2]];
				end
			end
			else if (req)
			begin
				if (waited >= delay)
				begin
					ack    <= 1'b1;
					waited <= '0;
				end
				else
					waited <= waited + 1'b1;
			end
			else
				waited <= '0;
		end
	end

endmodule

// File: test/xbar_tb.sv
// Testbench for xbar_top with 4 masters and 4 memory slave models.
// Rows of a stimulus table go to per-master queues; a row flagged 'together'
// starts in the same cycle as the next row. Each master presents its next row
// as soon as the previous one is acked. Expected read data comes from a
// shadow copy of every slave memory, updated in ack order.

`timescale 1ns/100ps

module xbar_tb;

	localparam int NUM_MASTERS = 4;
	localparam int NUM_SLAVES  = 4;
	localparam xbar_pkg::cmd_e RD = xbar_pkg::CMD_READ;
	localparam xbar_pkg::cmd_e WR = xbar_pkg::CMD_WRITE;

	typedef struct packed
	{
		logic [1:0]      master;
		xbar_pkg::cmd_e  cmd;
		xbar_pkg::addr_t addr;
		xbar_pkg::data_t wdata;
		logic            together;
		logic            rr;
	} row_t;

	logic                                     clk;
	logic                                     reset_n;
	logic [NUM_MASTERS-1:0]                   m_req;
	xbar_pkg::addr_t [NUM_MASTERS-1:0]        m_addr;
	xbar_pkg::cmd_e [NUM_MASTERS-1:0]         m_cmd;
	xbar_pkg::data_t [NUM_MASTERS-1:0]        m_wdata;
	logic [NUM_MASTERS-1:0]                   m_ack;
	logic [NUM_MASTERS-1:0]                   m_resp;
	xbar_pkg::data_t [NUM_MASTERS-1:0]        m_rdata;
	logic [NUM_SLAVES-1:0]                    s_req;
	xbar_pkg::addr_t [NUM_SLAVES-1:0]         s_addr;
	xbar_pkg::cmd_e [NUM_SLAVES-1:0]          s_cmd;
	xbar_pkg::data_t [NUM_SLAVES-1:0]         s_wdata;
	logic [NUM_SLAVES-1:0]                    s_ack;
	logic [NUM_SLAVES-1:0]                    s_resp;
	xbar_pkg::data_t [NUM_SLAVES-1:0]         s_rdata;
	logic [NUM_SLAVES-1:0][1:0]               ack_delay;

	row_t            rows [$];
	row_t            pend_q [NUM_MASTERS][$];
	row_t            cur_row [NUM_MASTERS];
	logic            busy [NUM_MASTERS];
	logic            read_due [NUM_MASTERS];
	xbar_pkg::data_t expect_rdata [NUM_MASTERS];
	xbar_pkg::data_t shadow [NUM_SLAVES][16];
	int              ack_order [$];
	logic [31:0]     rng_state;
	int              error_count;
	int              check_count;
	int              cycle_count;
	int              timeout_limit;

	xbar_top #(.NUM_MASTERS(NUM_MASTERS), .NUM_SLAVES(NUM_SLAVES)) dut
	(
		.clk(clk), .reset_n(reset_n),
		.m_req(m_req), .m_addr(m_addr), .m_cmd(m_cmd), .m_wdata(m_wdata),
		.m_ack(m_ack), .m_resp(m_resp), .m_rdata(m_rdata),
		.s_req(s_req), .s_addr(s_addr), .s_cmd(s_cmd), .s_wdata(s_wdata),
		.s_ack(s_ack), .s_resp(s_resp), .s_rdata(s_rdata)
	);

	for (genvar s = 0; s < NUM_SLAVES; s++)
	begin : g_model
		xbar_slave_model #(.SLAVE_ID(s)) u_model
		(
			.clk(clk), .reset_n(reset_n), .delay(ack_delay[s]),
			.req(s_req[s]), .addr(s_addr[s]), .cmd(s_cmd[s]), .wdata(s_wdata[s]),
			.ack(s_ack[s]), .resp(s_resp[s]), .rdata(s_rdata[s])
		);
	end

	always #5 clk = ~clk;

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic xbar_pkg::data_t preload_value(input int slave, input int word);
		return 32'hA000_0000 | (32'(slave) << 24) | (32'(word) << 8) | 32'(word ^ 15);
	endfunction

	function automatic bit all_idle();
		bit idle;
		idle = 1'b1;
		for (int m = 0; m < NUM_MASTERS; m++)
			if (busy[m] || read_due[m] || pend_q[m].size() != 0)
				idle = 1'b0;
		return idle;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		check_count++;
		if (got !== expected)
		begin
			error_count++;
			$display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got,
				expected);
		end
	endtask

	task automatic add_row(input int master, input xbar_pkg::cmd_e cmd,
		input logic [31:0] addr, input logic [31:0] wdata, input bit together, input bit rr);
		row_t r;
		r.master   = master[1:0];
		r.cmd      = cmd;
		r.addr     = addr;
		r.wdata    = wdata;
		r.together = together;
		r.rr       = rr;
		rows.push_back(r);
	endtask

	task automatic build_table();
		// write then read back on every slave plus one untouched word
		add_row(0, WR, 32'h0000_0004, 32'h1111_0001, 0, 0);
		add_row(0, RD, 32'h0000_0004, 32'h0, 0, 0);
		add_row(1, WR, 32'h4000_0008, 32'h2222_0002, 0, 0);
		add_row(1, RD, 32'h4000_0008, 32'h0, 0, 0);
		add_row(2, WR, 32'h8000_000C, 32'h3333_0003, 0, 0);
		add_row(2, RD, 32'h8000_000C, 32'h0, 0, 0);
		add_row(3, WR, 32'hC000_0010, 32'h4444_0004, 0, 0);
		add_row(3, RD, 32'hC000_0010, 32'h0, 0, 0);
		add_row(0, RD, 32'h4000_0020, 32'h0, 0, 0);
		// same low bits on different slaves
		add_row(1, WR, 32'h0000_0014, 32'hDEAD_0005, 0, 0);
		add_row(2, RD, 32'h4000_0014, 32'h0, 0, 0);
		add_row(0, RD, 32'h0000_0014, 32'h0, 0, 0);
		// four masters on four slaves at once
		add_row(0, RD, 32'h4000_0008, 32'h0, 1, 0);
		add_row(1, RD, 32'h8000_000C, 32'h0, 1, 0);
		add_row(2, WR, 32'hC000_0018, 32'h5555_0006, 1, 0);
		add_row(3, WR, 32'h0000_0018, 32'h6666_0007, 0, 0);
		// all masters on slave 2 with two rows each
		add_row(0, WR, 32'h8000_0000, 32'h7777_0000, 1, 1);
		add_row(1, WR, 32'h8000_0004, 32'h7777_0001, 1, 0);
		add_row(2, WR, 32'h8000_0008, 32'h7777_0002, 1, 0);
		add_row(3, WR, 32'h8000_000C, 32'h7777_0003, 1, 0);
		add_row(0, RD, 32'h8000_0004, 32'h0, 1, 0);
		add_row(1, RD, 32'h8000_0008, 32'h0, 1, 0);
		add_row(2, RD, 32'h8000_000C, 32'h0, 1, 0);
		add_row(3, RD, 32'h8000_0000, 32'h0, 0, 0);
		add_row(3, RD, 32'hC000_0018, 32'h0, 0, 0);
	endtask

	// ----------------------------------------------------------------------
	// random ack delays and cycle counter
	// ----------------------------------------------------------------------
	always @(posedge clk)
	begin
		rng_state = xorshift32(rng_state);
		for (int s = 0; s < NUM_SLAVES; s++)
			ack_delay[s] <= rng_state[2*s +: 2];
		cycle_count <= cycle_count + 1;
	end

	// per-master request driver and return checks
	always @(posedge clk)
	begin : master_drive
		int   sel;
		int   word;
		row_t nxt;
		if (reset_n)
		begin
			for (int m = 0; m < NUM_MASTERS; m++)
			begin
				// read data is due one cycle after its ack
				if (read_due[m])
				begin
					check_value($sformatf("m_resp[%0d]", m), 32'(m_resp[m]), 32'd1);
					check_value($sformatf("m_rdata[%0d]", m), m_rdata[m], expect_rdata[m]);
				end
				else
				begin
					check_value($sformatf("m_resp[%0d]", m), 32'(m_resp[m]), 32'd0);
					check_value($sformatf("m_rdata[%0d]", m), m_rdata[m], 32'd0);
				end
				read_due[m] = 1'b0;
				if (!busy[m])
					check_value($sformatf("m_ack[%0d]", m), 32'(m_ack[m]), 32'd0);
				else if (m_ack[m])
				begin
					sel  = int'(cur_row[m].addr[31:30]);
					word = int'(cur_row[m].addr[5:2]);
					// the acking slave still carries this master's request
					check_value($sformatf("s_req[%0d]", sel), 32'(s_req[sel]), 32'd1);
					check_value($sformatf("s_addr[%0d]", sel), s_addr[sel], cur_row[m].addr);
					check_value($sformatf("s_cmd[%0d]", sel), 32'(s_cmd[sel]),
						32'(cur_row[m].cmd));
					check_value($sformatf("s_wdata[%0d]", sel), s_wdata[sel],
						cur_row[m].wdata);
					if (cur_row[m].cmd == WR)
						shadow[sel][word] = cur_row[m].wdata;
					else
					begin
						expect_rdata[m] = shadow[sel][word];
						read_due[m]     = 1'b1;
					end
					ack_order.push_back(m);
					busy[m] = 1'b0;
					m_req[m] <= 1'b0;
				end
				if (!busy[m] && pend_q[m].size() > 0)
				begin
					nxt        = pend_q[m].pop_front();
					cur_row[m] = nxt;
					busy[m]    = 1'b1;
					m_req[m]   <= 1'b1;
					m_addr[m]  <= nxt.addr;
					m_cmd[m]   <= nxt.cmd;
					m_wdata[m] <= nxt.wdata;
				end
			end
		end
	end

	initial
	begin
		wait (timeout_limit > 0 && cycle_count >= timeout_limit);
		$display("timeout: transactions still open after %0d cycles", timeout_limit);
		$display("Result: FAILED");
		$finish;
	end

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------
	initial
	begin
		int i;
		bit check_rr;
		clk         = 1'b0;
		reset_n     = 1'b0;
		m_req       = '0;
		m_addr      = '0;
		m_wdata     = '0;
		ack_delay   = '0;
		rng_state   = 32'd98;
		error_count = 0;
		check_count = 0;
		cycle_count = 0;
		for (int m = 0; m < NUM_MASTERS; m++)
		begin
			m_cmd[m]    = RD;
			busy[m]     = 1'b0;
			read_due[m] = 1'b0;
		end
		for (int s = 0; s < NUM_SLAVES; s++)
			for (int w = 0; w < 16; w++)
				shadow[s][w] = preload_value(s, w);
		build_table();
		timeout_limit = rows.size() * 8 + 50;

		repeat (3) @(posedge clk);
		reset_n <= 1'b1;
		@(negedge clk);
		check_value("s_req", 32'(s_req), 32'd0);
		check_value("m_ack", 32'(m_ack), 32'd0);
		check_value("m_resp", 32'(m_resp), 32'd0);

		i = 0;
		while (i < rows.size())
		begin
			check_rr = rows[i].rr;
			ack_order.delete();
			do
			begin
				pend_q[rows[i].master].push_back(rows[i]);
				i++;
			end
			while (rows[i-1].together && i < rows.size());
			do
				@(negedge clk);
			while (!all_idle());
			// acks rotate through the masters while all of them request
			if (check_rr)
				for (int k = 1; k < ack_order.size(); k++)
					check_value("m_ack master order", 32'(ack_order[k]),
						32'((ack_order[k-1] + 1) % NUM_MASTERS));
		end

		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: xbar.f
design/xbar_pkg.sv
design/xbar_rr_arbiter.sv
design/xbar_slave_port.sv
design/xbar_return_router.sv
design/xbar_top.sv
test/xbar_slave_model.sv
test/xbar_tb.sv
